// File: DmaController.f
verilog/DmaPkg.sv
verilog/DmaHostPort.sv
verilog/DmaChannelRegs.sv
verilog/DmaModeRegs.sv
verilog/DmaTransferFsm.sv
verilog/DmaController.sv
sim/ClockGen.sv
sim/DmaTb.sv

// File: sim/ClockGen.sv
// Testbench clock and reset
module ClockGen (
  output logic dma_if,
  output logic rstN
);

  initial
  begin
    dma_if = 1'b0;
    forever #2 dma_if = ~dma_if;
  end

  // Reset held for 16 cycles
  initial
  begin
    rstN = 1'b0;
    repeat (16) @(posedge dma_if);
    rstN <= 1'b1;
  end

endmodule

// File: sim/DmaTb.sv
// DMA controller testbench
module DmaTb;
  import DmaPkg::*;

  logic    dma_if;
  logic    rstN;
  logic    csN;
  logic    iowN;
  logic    iorN;
  regAddrT addr;
  byteT    wrData;
  byteT    rdData;
  logic    busValid;
  wordT    busAddr;
  chanT    busChannel;
  logic    busTc;
  logic    busReady;

  integer seed = 6922;

  // Reference model state
  wordT                   mBaseAddr [numChannels];
  wordT                   mBaseCnt [numChannels];
  wordT                   mCurAddr [numChannels];
  wordT                   mCurCnt [numChannels];
  modeWordT               mMode [numChannels];
  logic                   mPtr;
  logic [numChannels-1:0] mReq;
  logic [numChannels-1:0] mMask;
  logic [numChannels-1:0] mTc;

  ClockGen clkGen (.dma_if(dma_if), .rstN(rstN));

  DmaController dut (
    .dma_if(dma_if), .rstN(rstN), .csN(csN), .iowN(iowN), .iorN(iorN),
    .addr(addr), .wrData(wrData), .rdData(rdData), .busValid(busValid),
    .busAddr(busAddr), .busChannel(busChannel), .busTc(busTc), .busReady(busReady)
  );

  // Memory side stalls at random
  always @(posedge dma_if)
    busReady <= (($random(seed) % 3) != 0);

  task automatic abortRun();
    $display("sim failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic reportTimeout(string what);
    $display("Timed out at time %0t while waiting for %s", $time, what);
    abortRun();
  endtask

  task automatic checkByte(byteT act, byteT exp, string what);
    if (act !== exp)
    begin
      $display("FAILED at time %0t: %s is 0x%02h, expected 0x%02h", $time, what, act, exp);
      abortRun();
    end
  endtask

  task automatic checkWord(wordT act, wordT exp, string what);
    if (act !== exp)
    begin
      $display("FAILED at time %0t: %s is 0x%04h, expected 0x%04h", $time, what, act, exp);
      abortRun();
    end
  endtask

  task automatic checkChan(chanT act, chanT exp, string what);
    if (act !== exp)
    begin
      $display("FAILED at time %0t: %s is %0d, expected %0d", $time, what, act, exp);
      abortRun();
    end
  endtask

  task automatic checkFlag(logic act, logic exp, string what);
    if (act !== exp)
    begin
      $display("FAILED at time %0t: %s is %b, expected %b", $time, what, act, exp);
      abortRun();
    end
  endtask

  function automatic regAddrT chanOffset(chanT ch, logic isCount);
    return regAddrT'({1'b0, ch, isCount});
  endfunction

  function automatic byteT modeByte(chanT ch, logic [1:0] xm, logic dec, logic ai);
    dmaDataU u;
    u = '0;
    u.mode.xferMode = xm;
    u.mode.decrement = dec;
    u.mode.autoInit = ai;
    u.mode.channel = ch;
    return u;
  endfunction

  function automatic byteT chanBitByte(chanT ch, logic setBit);
    dmaDataU u;
    u = '0;
    u.chanBit.setBit = setBit;
    u.chanBit.channel = ch;
    return u;
  endfunction

  task automatic clearModel();
    for (int i = 0; i < numChannels; i++)
    begin
      mBaseAddr[i] = '0;
      mBaseCnt[i] = '0;
      mCurAddr[i] = '0;
      mCurCnt[i] = '0;
      mMode[i] = '0;
    end
    mPtr = 1'b0;
    mReq = '0;
    mMask = '0;
    mTc = '0;
  endtask

  task automatic modelWrite(regAddrT a, byteT d);
    dmaDataU u;
    chanT    ch;
    u = d;
    ch = a[2:1];
    if (!a[3])
    begin
      // Base and current both take the byte
      if (a[0] && mPtr)
      begin
        mBaseCnt[ch][15:8] = d;
        mCurCnt[ch][15:8] = d;
      end
      else if (a[0])
      begin
        mBaseCnt[ch][7:0] = d;
        mCurCnt[ch][7:0] = d;
      end
      else if (mPtr)
      begin
        mBaseAddr[ch][15:8] = d;
        mCurAddr[ch][15:8] = d;
      end
      else
      begin
        mBaseAddr[ch][7:0] = d;
        mCurAddr[ch][7:0] = d;
      end
      mPtr = !mPtr;
    end
    else if (a == regRequest)
      mReq[u.chanBit.channel] = u.chanBit.setBit;
    else if (a == regSingleMask)
      mMask[u.chanBit.channel] = u.chanBit.setBit;
    else if (a == regMode)
      mMode[u.mode.channel] = u.mode;
    else if (a == regClearFf)
      mPtr = 1'b0;
    else if (a == regMasterClear)
      clearModel();
    else if (a == regClearMask)
      mMask = '0;
    else if (a == regAllMask)
      mMask = d[3:0];
  endtask

  task automatic regWrite(regAddrT a, byteT d);
    @(posedge dma_if);
    csN <= 1'b0;
    iowN <= 1'b0;
    addr <= a;
    wrData <= d;
    @(posedge dma_if);
    csN <= 1'b1;
    iowN <= 1'b1;
    modelWrite(a, d);
  endtask

  task automatic regRead(regAddrT a, output byteT got);
    byteT exp;
    wordT w;
    if (!a[3])
    begin
      w = a[0] ? mCurCnt[a[2:1]] : mCurAddr[a[2:1]];
      exp = mPtr ? w[15:8] : w[7:0];
      mPtr = !mPtr;
    end
    else if (a == regCmdStatus)
    begin
      exp = {mReq, mTc};
      mTc = '0;
    end
    else
      exp = '0;
    @(posedge dma_if);
    csN <= 1'b0;
    iorN <= 1'b0;
    addr <= a;
    @(posedge dma_if);
    csN <= 1'b1;
    iorN <= 1'b1;
    @(negedge dma_if);
    got = rdData;
    checkByte(got, exp, $sformatf("read data at offset %0d", a));
  endtask

  task automatic writeWord(chanT ch, logic isCount, wordT val);
    regWrite(regClearFf, '0);
    regWrite(chanOffset(ch, isCount), val[7:0]);
    regWrite(chanOffset(ch, isCount), val[15:8]);
  endtask

  // Optional restart re-reads the low byte after a flip-flop clear
  task automatic readWord(chanT ch, logic isCount, logic restart, output wordT w);
    byteT lo;
    byteT hi;
    regWrite(regClearFf, '0);
    regRead(chanOffset(ch, isCount), lo);
    if (restart)
    begin
      regWrite(regClearFf, '0);
      regRead(chanOffset(ch, isCount), lo);
    end
    regRead(chanOffset(ch, isCount), hi);
    w = {hi, lo};
  endtask

  task automatic stepModel(chanT ch, logic tc);
    if (tc)
    begin
      mTc[ch] = 1'b1;
      mReq[ch] = 1'b0;
    end
    if (tc && mMode[ch].autoInit)
    begin
      mCurAddr[ch] = mBaseAddr[ch];
      mCurCnt[ch] = mBaseCnt[ch];
    end
    else
    begin
      mCurAddr[ch] = mMode[ch].decrement ? mCurAddr[ch] - 1 : mCurAddr[ch] + 1;
      mCurCnt[ch] = mCurCnt[ch] - 1;
    end
  endtask

  // Follows every transfer the model expects, lowest channel first
  task automatic serveAll();
    logic [3:0] pend;
    chanT       ch;
    logic       tc;
    int         waitCnt;
    pend = mReq & ~mMask;
    @(negedge dma_if);
    while (pend != 0)
    begin
      if (pend[0])
        ch = 2'd0;
      else if (pend[1])
        ch = 2'd1;
      else if (pend[2])
        ch = 2'd2;
      else
        ch = 2'd3;
      tc = (mCurCnt[ch] == 0);
      waitCnt = 0;
      while (!(busValid && busReady))
      begin
        @(negedge dma_if);
        waitCnt++;
        if (waitCnt > 100)
          reportTimeout("a bus transfer");
      end
      checkChan(busChannel, ch, "bus channel");
      checkWord(busAddr, mCurAddr[ch], "bus address");
      checkFlag(busTc, tc, "bus TC");
      stepModel(ch, tc);
      @(negedge dma_if);
      // Only block mode keeps the bus without a new arbitration
      checkFlag(busValid, (mMode[ch].xferMode == xferModeBlock) && !tc,
                "bus valid after transfer");
      pend = mReq & ~mMask;
    end
  endtask

  task automatic checkQuiet(int cycles);
    repeat (cycles)
    begin
      @(negedge dma_if);
      checkFlag(busValid, 1'b0, "bus valid with no serviceable request");
    end
  endtask

  initial
  begin
    chanT       ch;
    byteT       rd;
    wordT       val;
    logic [3:0] maskBits;
    int         waitCnt;
    csN = 1'b1;
    iowN = 1'b1;
    iorN = 1'b1;
    addr = '0;
    wrData = '0;
    busReady = 1'b0;
    clearModel();
    waitCnt = 0;
    while (rstN !== 1'b1)
    begin
      @(posedge dma_if);
      waitCnt++;
      if (waitCnt > 40)
        reportTimeout("reset release");
    end

    // Register write and readback
    for (int i = 0; i < numChannels; i++)
    begin
      ch = chanT'(i);
      if ($random(seed) & 1)
      begin
        regWrite(chanOffset(ch, 1'b0), byteT'($random(seed)));
        regWrite(regClearFf, '0);
      end
      writeWord(ch, 1'b0, wordT'($random(seed)));
      writeWord(ch, 1'b1, wordT'($random(seed)));
    end
    for (int i = 0; i < numChannels; i++)
    begin
      readWord(chanT'(i), 1'b0, logic'($random(seed)), val);
      readWord(chanT'(i), 1'b1, logic'($random(seed)), val);
    end

    // Block mode, incrementing
    ch = chanT'($random(seed));
    regWrite(regCmdStatus, 8'h04);
    regWrite(regMode, modeByte(ch, xferModeBlock, 1'b0, 1'b0));
    writeWord(ch, 1'b0, wordT'($random(seed)));
    writeWord(ch, 1'b1, wordT'($random(seed) & 7));
    regWrite(regClearMask, '0);
    regWrite(regRequest, chanBitByte(ch, 1'b1));
    regWrite(regCmdStatus, '0);
    serveAll();
    checkQuiet(8);
    regRead(regCmdStatus, rd);
    regRead(regCmdStatus, rd);

    // Decrement with auto-initialize
    ch = chanT'($random(seed));
    regWrite(regCmdStatus, 8'h04);
    regWrite(regMode, modeByte(ch, xferModeBlock, 1'b1, 1'b1));
    writeWord(ch, 1'b0, wordT'($random(seed)));
    writeWord(ch, 1'b1, wordT'($random(seed) & 7));
    regWrite(regRequest, chanBitByte(ch, 1'b1));
    regWrite(regCmdStatus, '0);
    serveAll();
    checkQuiet(8);
    readWord(ch, 1'b0, 1'b0, val);
    checkWord(val, mBaseAddr[ch], "reloaded current address");
    readWord(ch, 1'b1, 1'b0, val);
    checkWord(val, mBaseCnt[ch], "reloaded current count");
    regRead(regCmdStatus, rd);

    // Single mode on all channels with a random mask
    regWrite(regCmdStatus, 8'h04);
    for (int i = 0; i < numChannels; i++)
    begin
      ch = chanT'(i);
      regWrite(regMode, modeByte(ch, xferModeSingle, 1'b0, 1'b0));
      writeWord(ch, 1'b0, wordT'($random(seed)));
      writeWord(ch, 1'b1, wordT'($random(seed) & 3));
    end
    maskBits = 4'($random(seed));
    if (maskBits == 4'hf)
      maskBits = 4'he;
    regWrite(regAllMask, {4'h0, maskBits});
    for (int i = 0; i < numChannels; i++)
      regWrite(regRequest, chanBitByte(chanT'(i), 1'b1));
    regWrite(regCmdStatus, '0);
    serveAll();
    checkQuiet(24);
    regRead(regCmdStatus, rd);

    // Disabled controller ignores unmasked requests
    regWrite(regCmdStatus, 8'h04);
    for (int i = 0; i < numChannels; i++)
      regWrite(regRequest, chanBitByte(chanT'(i), 1'b1));
    regWrite(regClearMask, '0);
    checkQuiet(24);

    // Master clear with the byte pointer left high
    regWrite(regClearFf, '0);
    regRead(chanOffset(2'd0, 1'b0), rd);
    regWrite(regMasterClear, '0);
    for (int i = 0; i < numChannels; i++)
    begin
      regRead(chanOffset(chanT'(i), 1'b0), rd);
      regRead(chanOffset(chanT'(i), 1'b0), rd);
      regRead(chanOffset(chanT'(i), 1'b1), rd);
      regRead(chanOffset(chanT'(i), 1'b1), rd);
    end
    regRead(regCmdStatus, rd);
    // A nonzero byte shows which half the pointer selects
    regWrite(chanOffset(2'd0, 1'b0), byteT'($random(seed)) | 8'h01);
    readWord(2'd0, 1'b0, 1'b0, val);
    checkQuiet(16);

    $display("sim passed");
    $finish;
  end

endmodule

// File: verilog/DmaChannelRegs.sv
// Channel address and count registers
module DmaChannelRegs (
  input  logic         dma_if,
  input  logic         rstN,
  input  logic         masterClear,
  input  logic         chanWrite,
  input  DmaPkg::chanT writeChan,
  input  logic         writeCount,
  input  logic         writeHigh,
  input  DmaPkg::byteT wrData,
  input  DmaPkg::chanT rdChan,
  input  logic         rdCount,
  input  DmaPkg::chanT activeChan,
  input  logic         stepEn,
  input  logic         decrement,
  input  logic         autoInit,
  output DmaPkg::wordT chanRdWord,
  output DmaPkg::wordT activeAddr,
  output logic         tcPulse
);
  import DmaPkg::*;

  wordT baseAddr [numChannels];
  wordT baseCount [numChannels];
  wordT currAddr [numChannels];
  wordT currCount [numChannels];
  logic activeZero;

  // Replace one byte of a 16-bit register
  function automatic wordT putByte(wordT old, byteT data, logic high);
    wordT word;
    word = old;
    if (high)
      word[15:8] = data;
    else
      word[7:0] = data;
    return word;
  endfunction

  assign activeZero = (currCount[activeChan] == '0);
  assign tcPulse    = stepEn && activeZero;
  assign activeAddr = currAddr[activeChan];
  assign chanRdWord = rdCount ? currCount[rdChan] : currAddr[rdChan];

  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN || masterClear)
    begin
      for (int i = 0; i < numChannels; i++)
      begin
        baseAddr[i]  <= '0;
        baseCount[i] <= '0;
      end
    end
    else if (chanWrite)
    begin
      if (writeCount)
        baseCount[writeChan] <= putByte(baseCount[writeChan], wrData, writeHigh);
      else
        baseAddr[writeChan] <= putByte(baseAddr[writeChan], wrData, writeHigh);
    end
  end

  // Stepping wins over a CPU write to the same channel
  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < numChannels; i++)
      begin
        currAddr[i]  <= '0;
        currCount[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < numChannels; i++)
      begin
        if (masterClear)
        begin
          currAddr[i]  <= '0;
          currCount[i] <= '0;
        end
        else if (stepEn && (activeChan == chanT'(i)))
        begin
          if (activeZero && autoInit)
          begin
            currAddr[i]  <= baseAddr[i];
            currCount[i] <= baseCount[i];
          end
          else
          begin
            currAddr[i]  <= decrement ? currAddr[i] - 16'd1 : currAddr[i] + 16'd1;
            // Count wraps from zero to all ones
            currCount[i] <= currCount[i] - 16'd1;
          end
        end
        else if (chanWrite && (writeChan == chanT'(i)))
        begin
          if (writeCount)
            currCount[i] <= putByte(currCount[i], wrData, writeHigh);
          else
            currAddr[i] <= putByte(currAddr[i], wrData, writeHigh);
        end
      end
    end
  end

endmodule

// File: verilog/DmaController.sv
// Four channel DMA controller top
module DmaController (
  input  logic            dma_if,
  input  logic            rstN,
  input  logic            csN,
  input  logic            iowN,
  input  logic            iorN,
  input  DmaPkg::regAddrT addr,
  input  DmaPkg::byteT    wrData,
  output DmaPkg::byteT    rdData,
  output logic            busValid,
  output DmaPkg::wordT    busAddr,
  output DmaPkg::chanT    busChannel,
  output logic            busTc,
  input  logic            busReady
);
  import DmaPkg::*;

  // Host port strobes
  chanT rdChan;
  logic rdCount;
  logic chanWrite;
  chanT writeChan;
  logic writeCount;
  logic writeHigh;
  logic modeWrite;
  logic cmdWrite;
  logic requestWrite;
  logic singleMaskWrite;
  logic allMaskWrite;
  logic clearMask;
  logic statusRead;
  logic masterClear;

  // Register and engine state
  wordT                   chanRdWord;
  byteT                   statusByte;
  wordT                   activeAddr;
  chanT                   activeChan;
  logic                   tcPulse;
  logic                   stepEn;
  logic [numChannels-1:0] pending;
  logic                   enable;
  logic [1:0]             xferMode;
  logic                   decrement;
  logic                   autoInit;

  DmaHostPort hostPort (
    .dma_if(dma_if), .rstN(rstN), .csN(csN), .iowN(iowN), .iorN(iorN),
    .addr(addr), .wrData(wrData), .chanRdWord(chanRdWord), .statusByte(statusByte),
    .rdChan(rdChan), .rdCount(rdCount), .chanWrite(chanWrite),
    .writeChan(writeChan), .writeCount(writeCount), .writeHigh(writeHigh),
    .modeWrite(modeWrite), .cmdWrite(cmdWrite), .requestWrite(requestWrite),
    .singleMaskWrite(singleMaskWrite), .allMaskWrite(allMaskWrite),
    .clearMask(clearMask), .statusRead(statusRead), .masterClear(masterClear),
    .rdData(rdData)
  );

  DmaChannelRegs chanRegs (
    .dma_if(dma_if), .rstN(rstN), .masterClear(masterClear), .chanWrite(chanWrite),
    .writeChan(writeChan), .writeCount(writeCount), .writeHigh(writeHigh),
    .wrData(wrData), .rdChan(rdChan), .rdCount(rdCount), .activeChan(activeChan),
    .stepEn(stepEn), .decrement(decrement), .autoInit(autoInit),
    .chanRdWord(chanRdWord), .activeAddr(activeAddr), .tcPulse(tcPulse)
  );

  DmaModeRegs modeRegs (
    .dma_if(dma_if), .rstN(rstN), .masterClear(masterClear), .modeWrite(modeWrite),
    .cmdWrite(cmdWrite), .requestWrite(requestWrite),
    .singleMaskWrite(singleMaskWrite), .allMaskWrite(allMaskWrite),
    .clearMask(clearMask), .statusRead(statusRead), .wrData(wrData),
    .activeChan(activeChan), .tcPulse(tcPulse), .pending(pending), .enable(enable),
    .xferMode(xferMode), .decrement(decrement), .autoInit(autoInit),
    .statusByte(statusByte)
  );

  DmaTransferFsm xferFsm (
    .dma_if(dma_if), .rstN(rstN), .pending(pending), .enable(enable),
    .xferMode(xferMode), .tcPulse(tcPulse), .busReady(busReady),
    .activeAddr(activeAddr), .activeChan(activeChan), .stepEn(stepEn),
    .busValid(busValid), .busAddr(busAddr), .busChannel(busChannel), .busTc(busTc)
  );

endmodule

// File: verilog/DmaHostPort.sv
// CPU register port
module DmaHostPort (
  input  logic            dma_if,
  input  logic            rstN,
  input  logic            csN,
  input  logic            iowN,
  input  logic            iorN,
  input  DmaPkg::regAddrT addr,
  input  DmaPkg::byteT    wrData,
  input  DmaPkg::wordT    chanRdWord,
  input  DmaPkg::byteT    statusByte,
  output DmaPkg::chanT    rdChan,
  output logic            rdCount,
  output logic            chanWrite,
  output DmaPkg::chanT    writeChan,
  output logic            writeCount,
  output logic            writeHigh,
  output logic            modeWrite,
  output logic            cmdWrite,
  output logic            requestWrite,
  output logic            singleMaskWrite,
  output logic            allMaskWrite,
  output logic            clearMask,
  output logic            statusRead,
  output logic            masterClear,
  output DmaPkg::byteT    rdData
);
  import DmaPkg::*;

  logic wrStb;
  logic rdStb;
  logic chanAccess;
  logic bytePtr;
  byteT rdNext;

  assign wrStb = !csN && !iowN;
  assign rdStb = !csN && !iorN;
  assign chanAccess = !addr[3];

  // Channel register offset: bits 2:1 pick the channel, bit 0 the count
  assign chanWrite  = wrStb && chanAccess;
  assign writeChan  = addr[2:1];
  assign writeCount = addr[0];
  assign writeHigh  = bytePtr;
  assign rdChan     = addr[2:1];
  assign rdCount    = addr[0];

  assign cmdWrite        = wrStb && (addr == regCmdStatus);
  assign requestWrite    = wrStb && (addr == regRequest);
  assign singleMaskWrite = wrStb && (addr == regSingleMask);
  assign modeWrite       = wrStb && (addr == regMode);
  assign masterClear     = wrStb && (addr == regMasterClear);
  assign clearMask       = wrStb && (addr == regClearMask);
  assign allMaskWrite    = wrStb && (addr == regAllMask);
  assign statusRead      = rdStb && (addr == regCmdStatus);

  always_comb
  begin
    if (chanAccess)
      rdNext = bytePtr ? chanRdWord[15:8] : chanRdWord[7:0];
    else if (addr == regCmdStatus)
      rdNext = statusByte;
    else
      rdNext = '0;
  end

  // Byte pointer flips on every channel register access
  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
      bytePtr <= 1'b0;
    else if (masterClear || (wrStb && (addr == regClearFf)))
      bytePtr <= 1'b0;
    else if ((wrStb || rdStb) && chanAccess)
      bytePtr <= !bytePtr;
  end

  // Read data holds until the next read
  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
      rdData <= '0;
    else if (rdStb)
      rdData <= rdNext;
  end

endmodule

// File: verilog/DmaModeRegs.sv
// Mode, command, request, mask and status registers
module DmaModeRegs (
  input  logic                           dma_if,
  input  logic                           rstN,
  input  logic                           masterClear,
  input  logic                           modeWrite,
  input  logic                           cmdWrite,
  input  logic                           requestWrite,
  input  logic                           singleMaskWrite,
  input  logic                           allMaskWrite,
  input  logic                           clearMask,
  input  logic                           statusRead,
  input  DmaPkg::byteT                   wrData,
  input  DmaPkg::chanT                   activeChan,
  input  logic                           tcPulse,
  output logic [DmaPkg::numChannels-1:0] pending,
  output logic                           enable,
  output logic [1:0]                     xferMode,
  output logic                           decrement,
  output logic                           autoInit,
  output DmaPkg::byteT                   statusByte
);
  import DmaPkg::*;

  dmaDataU                data;
  modeWordT               modeReg [numChannels];
  modeWordT               activeMode;
  byteT                   cmdReg;
  logic [numChannels-1:0] requestReg;
  logic [numChannels-1:0] maskReg;
  logic [numChannels-1:0] tcFlags;

  assign data = wrData;

  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN || masterClear)
    begin
      for (int i = 0; i < numChannels; i++)
        modeReg[i] <= '0;
      cmdReg <= '0;
    end
    else
    begin
      if (modeWrite)
        modeReg[data.mode.channel] <= data.mode;
      if (cmdWrite)
        cmdReg <= wrData;
    end
  end

  // A CPU request write lands after the TC clear
  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN || masterClear)
    begin
      requestReg <= '0;
      maskReg    <= '0;
      tcFlags    <= '0;
    end
    else
    begin
      if (tcPulse)
        requestReg[activeChan] <= 1'b0;
      if (requestWrite)
        requestReg[data.chanBit.channel] <= data.chanBit.setBit;
      if (clearMask)
        maskReg <= '0;
      else if (allMaskWrite)
        maskReg <= wrData[numChannels-1:0];
      else if (singleMaskWrite)
        maskReg[data.chanBit.channel] <= data.chanBit.setBit;
      // TC flags clear on a status read, a new TC still sets
      if (statusRead)
        tcFlags <= '0;
      if (tcPulse)
        tcFlags[activeChan] <= 1'b1;
    end
  end

  assign activeMode = modeReg[activeChan];
  assign pending    = requestReg & ~maskReg;
  assign enable     = !cmdReg[cmdDisableBit];
  assign xferMode   = activeMode.xferMode;
  assign decrement  = activeMode.decrement;
  assign autoInit   = activeMode.autoInit;
  assign statusByte = {requestReg, tcFlags};

endmodule

// File: verilog/DmaPkg.sv
// DMA controller shared definitions
package DmaPkg;

  localparam int numChannels = 4;

  typedef logic [1:0]  chanT;
  typedef logic [3:0]  regAddrT;
  typedef logic [7:0]  byteT;
  typedef logic [15:0] wordT;

  // Offsets 0 to 7 are the channel address and count registers
  localparam regAddrT regCmdStatus   = 4'd8;
  localparam regAddrT regRequest     = 4'd9;
  localparam regAddrT regSingleMask  = 4'd10;
  localparam regAddrT regMode        = 4'd11;
  localparam regAddrT regClearFf     = 4'd12;
  localparam regAddrT regMasterClear = 4'd13;
  localparam regAddrT regClearMask   = 4'd14;
  localparam regAddrT regAllMask     = 4'd15;

  // Command register bit that turns the whole controller off
  localparam int cmdDisableBit = 2;

  localparam logic [1:0] xferModeSingle = 2'b01;
  localparam logic [1:0] xferModeBlock  = 2'b10;

  // Mode register write layout
  typedef struct packed {
    logic [1:0] xferMode;
    logic       decrement;
    logic       autoInit;
    logic [1:0] reserved;
    chanT       channel;
  } modeWordT;

  // Request and single mask write layout
  typedef struct packed {
    logic [4:0] unused;
    logic       setBit;
    chanT       channel;
  } chanBitWordT;

  typedef union packed {
    modeWordT    mode;
    chanBitWordT chanBit;
  } dmaDataU;

  typedef enum logic {
    idle,
    transfer
  } fsmStateT;

endpackage

// File: verilog/DmaTransferFsm.sv
// Channel priority and memory handshake
module DmaTransferFsm (
  input  logic                           dma_if,
  input  logic                           rstN,
  input  logic [DmaPkg::numChannels-1:0] pending,
  input  logic                           enable,
  input  logic [1:0]                     xferMode,
  input  logic                           tcPulse,
  input  logic                           busReady,
  input  DmaPkg::wordT                   activeAddr,
  output DmaPkg::chanT                   activeChan,
  output logic                           stepEn,
  output logic                           busValid,
  output DmaPkg::wordT                   busAddr,
  output DmaPkg::chanT                   busChannel,
  output logic                           busTc
);
  import DmaPkg::*;

  fsmStateT state;
  chanT     nextChan;

  // Fixed priority, channel 0 highest
  function automatic chanT lowestChan(logic [numChannels-1:0] req);
    chanT ch;
    ch = '0;
    for (int i = numChannels - 1; i >= 0; i--)
      if (req[i])
        ch = chanT'(i);
    return ch;
  endfunction

  assign nextChan   = lowestChan(pending);
  assign busValid   = (state == transfer);
  assign stepEn     = busValid && busReady;
  assign busTc      = busValid && tcPulse;
  assign busAddr    = activeAddr;
  assign busChannel = activeChan;

  always_ff @(posedge dma_if or negedge rstN)
  begin
    if (!rstN)
    begin
      state      <= idle;
      activeChan <= '0;
    end
    else
    begin
      case (state)
        idle:
          if (enable && (|pending))
          begin
            activeChan <= nextChan;
            state      <= transfer;
          end
        transfer:
          if (stepEn)
          begin
            if (tcPulse)
              state <= idle;
            else
            begin
              // Block keeps the bus, single goes back to arbitration
              case (xferMode)
                xferModeBlock:  state <= transfer;
                xferModeSingle: state <= idle;
                default:        state <= idle;
              endcase
            end
          end
      endcase
    end
  end

endmodule
